//--- hdl/socBusPkg.sv
// bus word and address sizes plus the request / response structs
package socBusPkg;

    // data and byte address widths of the cpu bus
    localparam int dataWidth   = 32;
    localparam int addrWidth   = 32;
    // one byte enable per data byte
    localparam int bweWidth    = dataWidth / 8;
    // word offset inside a region, as a slave sees it
    localparam int offsetWidth = 12;

    // access as driven by the bus master
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [bweWidth-1:0]    bwe;
        logic [addrWidth-1:0]   address;
        logic [dataWidth-1:0]   writeData;
    } busReq;

    // access after region decode, strobes and bwe already gated
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [bweWidth-1:0]    bwe;
        logic [offsetWidth-1:0] offset;
        logic [dataWidth-1:0]   writeData;
    } slaveReq;

    // answer of one slave, valid for a single cycle
    typedef struct packed {
        logic                   readValid;
        logic [dataWidth-1:0]   readData;
    } slaveRsp;

    // merged answer back to the master
    typedef struct packed {
        logic                   readValid;
        logic [dataWidth-1:0]   readData;
    } busRsp;

endpackage

//--- hdl/socMapPkg.sv
// address map and interrupt line numbering of the peripheral side
package socMapPkg;

    // region select lives in the top address byte
    localparam int regionMsb   = 31;
    localparam int regionLsb   = 24;
    localparam int regionWidth = regionMsb - regionLsb + 1;

    // byte address bits 1:0 are dropped, word offsets start here
    localparam int offsetLsb   = 2;

    // region codes
    localparam logic [regionWidth-1:0] regionRam    = 8'd0;
    localparam logic [regionWidth-1:0] regionRandom = 8'd1;
    localparam logic [regionWidth-1:0] regionTimer  = 8'd2;

    // interrupt controller size
    localparam int irqLines    = 16;
    localparam int irqNumWidth = 4;

    // timer channels occupy lines from here upward
    localparam int irqTimerBase = 0;

endpackage

//--- hdl/busInterconnect.sv
`timescale 1ns/1ps

module busInterconnect (
    input   logic                   clk,
    input   logic                   arstN,

    input   socBusPkg::busReq       req,
    output  socBusPkg::busRsp       rsp,

    output  socBusPkg::slaveReq     ramReq,
    output  socBusPkg::slaveReq     randomReq,
    output  socBusPkg::slaveReq     timerReq,

    input   socBusPkg::slaveRsp     ramRsp,
    input   socBusPkg::slaveRsp     randomRsp,
    input   socBusPkg::slaveRsp     timerRsp
);

    // region field of the current access
    logic  [socMapPkg::regionWidth-1:0]  region;

    // one-hot region hits
    logic          hitRam;
    logic          hitRandom;
    logic          hitTimer;
    logic          hitNone;

    // unmapped read answered by the interconnect itself
    logic          unmappedValid;

    // build a slave access, strobes only when the region matches
    function automatic socBusPkg::slaveReq steer(
        input socBusPkg::busReq r,
        input logic             hit
    );
        socBusPkg::slaveReq s;
        s.read      = r.read & hit;
        s.write     = r.write & hit;
        // bwe only meaningful on a steered write
        s.bwe       = r.bwe & {socBusPkg::bweWidth{r.write & hit}};
        s.offset    = r.address[socMapPkg::offsetLsb +: socBusPkg::offsetWidth];
        s.writeData = r.writeData;
        return s;
    endfunction

    assign region    = req.address[socMapPkg::regionMsb:socMapPkg::regionLsb];

    assign hitRam    = (region == socMapPkg::regionRam);
    assign hitRandom = (region == socMapPkg::regionRandom);
    assign hitTimer  = (region == socMapPkg::regionTimer);
    assign hitNone   = ~(hitRam | hitRandom | hitTimer);

    assign ramReq    = steer(req, hitRam);
    assign randomReq = steer(req, hitRandom);
    assign timerReq  = steer(req, hitTimer);

    // flag an unmapped read, answered next cycle like any slave
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            unmappedValid <= 1'b0;
        end else begin
            unmappedValid <= req.read & hitNone;
        end
    end

    // at most one responder per cycle, pick whichever is valid
    always_comb begin
        rsp.readValid = 1'b0;
        rsp.readData  = '0;
        if (ramRsp.readValid) begin
            rsp.readValid = 1'b1;
            rsp.readData  = ramRsp.readData;
        end else if (randomRsp.readValid) begin
            rsp.readValid = 1'b1;
            rsp.readData  = randomRsp.readData;
        end else if (timerRsp.readValid) begin
            rsp.readValid = 1'b1;
            rsp.readData  = timerRsp.readData;
        end else if (unmappedValid) begin
            // zero word, keeps the master from hanging
            rsp.readValid = 1'b1;
        end
    end

endmodule

//--- hdl/scratchRam.sv
`timescale 1ns/1ps

module scratchRam #(
    parameter int ramAddrWidth = 10
)(
    input   logic                   clk,
    input   logic                   arstN,

    input   socBusPkg::slaveReq     req,
    output  socBusPkg::slaveRsp     rsp
);

    // word storage
    logic  [socBusPkg::dataWidth-1:0]  mem [2**ramAddrWidth];

    // word index from the low offset bits
    logic  [ramAddrWidth-1:0]          wordAddr;

    // read return path
    logic                              readValid;
    logic  [socBusPkg::dataWidth-1:0]  readData;

    assign wordAddr = req.offset[ramAddrWidth-1:0];

    // byte-lane writes, registered read
    always_ff @(posedge clk) begin
        if (req.write) begin
            for (int b = 0; b < socBusPkg::bweWidth; b++) begin
                if (req.bwe[b]) begin
                    mem[wordAddr][b*8 +: 8] <= req.writeData[b*8 +: 8];
                end
            end
        end
        if (req.read) begin
            readData <= mem[wordAddr];
        end
    end

    // one-cycle valid after each read strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    assign rsp.readValid = readValid;
    assign rsp.readData  = readData;

endmodule

//--- hdl/lfsrRandom.sv
`timescale 1ns/1ps

module lfsrRandom (
    input   logic                   clk,
    input   logic                   arstN,

    input   socBusPkg::slaveReq     req,
    output  socBusPkg::slaveRsp     rsp
);

    // galois taps 32, 22, 2, 1 for a right-shifting register
    localparam logic [31:0] tapMask = 32'h8020_0003;

    // generator state and its next step
    logic  [31:0]                      state;
    logic  [31:0]                      nextState;

    // read return path
    logic                              readValid;
    logic  [socBusPkg::dataWidth-1:0]  readData;

    // shift right, fold taps in when a one drops out
    assign nextState = {1'b0, state[31:1]} ^ (state[0] ? tapMask : 32'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= 32'd1;
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
            // zero seed would lock the register up
            if (req.write && (req.writeData != '0)) begin
                state <= req.writeData;
            end else if (req.read) begin
                state <= nextState;
            end
        end
    end

    // value handed out is the state before the step
    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= state;
        end
    end

    assign rsp.readValid = readValid;
    assign rsp.readData  = readData;

endmodule

//--- hdl/systemTimer.sv
`timescale 1ns/1ps

module systemTimer #(
    parameter int timerCount = 3
)(
    input   logic                   clk,
    input   logic                   arstN,

    input   socBusPkg::slaveReq     req,
    output  socBusPkg::slaveRsp     rsp,

    output  logic [timerCount-1:0]  timerIrq
);

    // register file layout
    // 0 .. n-1   reload values
    // n .. 2n-1  live counts, read only
    // 2n         enable mask
    localparam int countBase  = timerCount;
    localparam int enableAddr = 2 * timerCount;

    // per-channel reload and live count
    logic  [socBusPkg::dataWidth-1:0]  reload [timerCount];
    logic  [socBusPkg::dataWidth-1:0]  count  [timerCount];
    logic  [timerCount-1:0]            enable;

    // read return path
    logic  [socBusPkg::dataWidth-1:0]  readMux;
    logic                              readValid;
    logic  [socBusPkg::dataWidth-1:0]  readData;

    // irq fires in the cycle an enabled counter sits at zero
    always_comb begin
        for (int k = 0; k < timerCount; k++) begin
            timerIrq[k] = enable[k] && (count[k] == '0);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < timerCount; k++) begin
                reload[k] <= '0;
                count[k]  <= '0;
            end
            enable    <= '0;
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
            for (int k = 0; k < timerCount; k++) begin
                // reload write also restarts the count
                if (req.write && (req.offset == k)) begin
                    reload[k] <= req.writeData;
                    count[k]  <= req.writeData;
                end else if (timerIrq[k]) begin
                    count[k] <= reload[k];
                end else if (enable[k]) begin
                    count[k] <= count[k] - 1'b1;
                end
            end
            if (req.write && (req.offset == enableAddr)) begin
                enable <= req.writeData[timerCount-1:0];
            end
        end
    end

    // addressed register, zero for holes
    always_comb begin
        readMux = '0;
        for (int k = 0; k < timerCount; k++) begin
            if (req.offset == k) begin
                readMux = reload[k];
            end
            if (req.offset == countBase + k) begin
                readMux = count[k];
            end
        end
        if (req.offset == enableAddr) begin
            readMux[timerCount-1:0] = enable;
        end
    end

    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= readMux;
        end
    end

    assign rsp.readValid = readValid;
    assign rsp.readData  = readData;

endmodule

//--- hdl/interruptController.sv
`timescale 1ns/1ps

module interruptController (
    input   logic                                 clk,
    input   logic                                 arstN,

    input   logic [socMapPkg::irqLines-1:0]       triggerInterrupt,
    input   logic                                 interruptAcknowledge,
    input   logic [socMapPkg::irqNumWidth-1:0]    ackNumber,

    output  logic                                 interruptRequest,
    output  logic [socMapPkg::irqNumWidth-1:0]    irqNumber
);

    // latched interrupt lines
    logic  [socMapPkg::irqLines-1:0]  pending;

    // line being acknowledged this cycle
    logic  [socMapPkg::irqLines-1:0]  ackMask;

    always_comb begin
        ackMask = '0;
        if (interruptAcknowledge) begin
            ackMask[ackNumber] = 1'b1;
        end
    end

    // fresh trigger beats a clear on the same line
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~ackMask) | triggerInterrupt;
        end
    end

    assign interruptRequest = |pending;

    // fixed priority, lowest line number wins
    always_comb begin
        irqNumber = '0;
        for (int i = socMapPkg::irqLines - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irqNumber = socMapPkg::irqNumWidth'(i);
            end
        end
    end

endmodule

//--- hdl/decaSoc.sv
`timescale 1ns/1ps

module decaSoc #(
    parameter int ramAddrWidth = 10,
    parameter int timerCount   = 3
)(
    input   logic                                 clk,
    input   logic                                 arstN,

    // cpu bus
    input   socBusPkg::busReq                     req,
    output  socBusPkg::busRsp                     rsp,

    // interrupt handshake with the cpu
    input   logic                                 interruptAcknowledge,
    input   logic [socMapPkg::irqNumWidth-1:0]    ackNumber,
    output  logic                                 interruptRequest,
    output  logic [socMapPkg::irqNumWidth-1:0]    irqNumber
);

    // decoded slave accesses
    socBusPkg::slaveReq  ramReq;
    socBusPkg::slaveReq  randomReq;
    socBusPkg::slaveReq  timerReq;

    // slave answers
    socBusPkg::slaveRsp  ramRsp;
    socBusPkg::slaveRsp  randomRsp;
    socBusPkg::slaveRsp  timerRsp;

    // interrupt sources
    logic  [timerCount-1:0]           timerIrq;
    logic  [socMapPkg::irqLines-1:0]  triggerInterrupt;

    // timer channels from the base line up, the rest tied low
    always_comb begin
        triggerInterrupt = '0;
        triggerInterrupt[socMapPkg::irqTimerBase +: timerCount] = timerIrq;
    end

    busInterconnect
    busInterconnect_inst(
        .clk,
        .arstN,
        .req,
        .rsp,
        .ramReq,
        .randomReq,
        .timerReq,
        .ramRsp,
        .randomRsp,
        .timerRsp
    );

    scratchRam #(.ramAddrWidth(ramAddrWidth))
    scratchRam_inst(
        .clk,
        .arstN,
        .req                    (ramReq),
        .rsp                    (ramRsp)
    );

    lfsrRandom
    lfsrRandom_inst(
        .clk,
        .arstN,
        .req                    (randomReq),
        .rsp                    (randomRsp)
    );

    systemTimer #(.timerCount(timerCount))
    systemTimer_inst(
        .clk,
        .arstN,
        .req                    (timerReq),
        .rsp                    (timerRsp),
        .timerIrq
    );

    interruptController
    interruptController_inst(
        .clk,
        .arstN,
        .triggerInterrupt,
        .interruptAcknowledge,
        .ackNumber,
        .interruptRequest,
        .irqNumber
    );

endmodule

//--- verif/decaSocTb.sv
`timescale 1ns/1ps

module decaSocTb;

    // dut geometry
    localparam int ramAddrWidth = 10;
    localparam int timerCount   = 3;

    // test sizes that the watchdog budget is built from
    localparam int resetCycles    = 4;
    localparam int ramWords       = 12;
    localparam int lfsrReads      = 6;
    localparam int timerReload    = 12;
    localparam int timerPulses    = 3;
    localparam int watchdogCycles = resetCycles + 4 * ramWords + 2 * lfsrReads
                                  + (timerPulses + 2) * (timerReload + 4) + 100;

    // timer register layout
    localparam int countBase  = timerCount;
    localparam int enableAddr = 2 * timerCount;

    logic                                 clk;
    logic                                 arstN;
    socBusPkg::busReq                     req;
    socBusPkg::busRsp                     rsp;
    logic                                 interruptAcknowledge;
    logic [socMapPkg::irqNumWidth-1:0]    ackNumber;
    logic                                 interruptRequest;
    logic [socMapPkg::irqNumWidth-1:0]    irqNumber;

    // checking state
    int           errors;
    int           cycle;
    int           seed;
    logic [31:0]  expectedData [$];
    logic [31:0]  ramModel [2**ramAddrWidth];
    logic [31:0]  lfsrState;

    decaSoc #(
        .ramAddrWidth   (ramAddrWidth),
        .timerCount     (timerCount)
    ) decaSoc_inst (
        .clk,
        .arstN,
        .req,
        .rsp,
        .interruptAcknowledge,
        .ackNumber,
        .interruptRequest,
        .irqNumber
    );

    // 8 ns period
    always #4 clk = ~clk;

    // free running count for interval checks
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic expectEqual(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string reason);
        errors++;
        $display("%0t: %s", $time, reason);
    endtask

    // every read strobe answered in exactly the next cycle
    readAnswered: assert property (@(posedge clk) disable iff (!arstN)
        req.read |=> rsp.readValid)
        else reportFailure("read strobe got no readValid in the next cycle");

    noSpuriousValid: assert property (@(posedge clk) disable iff (!arstN)
        rsp.readValid |-> $past(req.read))
        else reportFailure("readValid without a read strobe one cycle before");

    // returned words against the reference models in issue order
    always @(posedge clk) begin
        if (arstN && rsp.readValid) begin
            if (expectedData.size() == 0) begin
                reportFailure("readValid with no read outstanding");
            end else begin
                expectEqual("rsp.readData", expectedData.pop_front(), rsp.readData);
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1 in right shifting galois form
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        logic [31:0] taps;
        taps = (32'd1 << 31) | (32'd1 << 21) | (32'd1 << 1) | 32'd1;
        return s[0] ? ((s >> 1) ^ taps) : (s >> 1);
    endfunction

    // region in the top byte and word offset from bit 2
    function automatic logic [31:0] addressOf(input logic [7:0] region, input int offset);
        return {region, 24'd0} | (32'(offset) << socMapPkg::offsetLsb);
    endfunction

    task automatic writeReg(input logic [7:0] region, input int offset,
                            input logic [3:0] bwe, input logic [31:0] data);
        @(posedge clk);
        req.read      <= 1'b0;
        req.write     <= 1'b1;
        req.bwe       <= bwe;
        req.address   <= addressOf(region, offset);
        req.writeData <= data;
    endtask

    task automatic readExpect(input logic [7:0] region, input int offset,
                              input logic [31:0] expected);
        @(posedge clk);
        req.read    <= 1'b1;
        req.write   <= 1'b0;
        req.bwe     <= '0;
        req.address <= addressOf(region, offset);
        expectedData.push_back(expected);
    endtask

    task automatic idleBus;
        @(posedge clk);
        req.read  <= 1'b0;
        req.write <= 1'b0;
    endtask

    // byte merge into the model before the bus write
    task automatic ramStore(input int word, input logic [3:0] bwe, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (bwe[b]) begin
                ramModel[word][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        writeReg(socMapPkg::regionRam, word, bwe, data);
    endtask

    task automatic lfsrRead;
        readExpect(socMapPkg::regionRandom, 0, lfsrState);
        lfsrState = nextLfsr(lfsrState);
    endtask

    task automatic checkIdleOutputs;
        expectEqual("rsp.readValid", 0, rsp.readValid);
        expectEqual("interruptRequest", 0, interruptRequest);
        expectEqual("irqNumber", 0, irqNumber);
    endtask

    // ack held high for one cycle from the calling edge
    task automatic acknowledge(input logic [3:0] num);
        interruptAcknowledge <= 1'b1;
        ackNumber            <= num;
        @(posedge clk);
        interruptAcknowledge <= 1'b0;
    endtask

    // hands back the cycle number of the first edge with the level high
    task automatic waitForRequest(input int limit, output int seenAt);
        int waited;
        waited = 0;
        seenAt = -1;
        while (seenAt < 0 && waited < limit) begin
            @(posedge clk);
            if (interruptRequest) begin
                seenAt = cycle;
            end
            waited++;
        end
        if (seenAt < 0) begin
            reportFailure("interruptRequest never rose");
        end
    endtask

    initial begin
        int words [ramWords];
        int riseAt;
        int prevRise;
        clk                  = 1'b0;
        arstN                = 1'b0;
        req                  = '0;
        interruptAcknowledge = 1'b0;
        ackNumber            = '0;
        errors               = 0;
        cycle                = 0;
        seed                 = 32'h064b5373;

        // outputs quiet in reset and just after
        repeat (resetCycles) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        checkIdleOutputs();

        // full ram words first so every byte is known
        for (int i = 0; i < ramWords; i++) begin
            words[i] = $random(seed) & (2**ramAddrWidth - 1);
            ramStore(words[i], 4'hf, $random(seed));
        end
        for (int i = 0; i < ramWords; i++) begin
            ramStore(words[i], 4'($random(seed)), $random(seed));
        end
        // back to back reads
        for (int i = 0; i < ramWords; i++) begin
            readExpect(socMapPkg::regionRam, words[i], ramModel[words[i]]);
        end
        idleBus();
        // spaced reads
        for (int i = 0; i < 4; i++) begin
            readExpect(socMapPkg::regionRam, words[i], ramModel[words[i]]);
            idleBus();
        end

        // lfsr seeded with any nonzero value
        lfsrState = $random(seed) | 32'h1;
        writeReg(socMapPkg::regionRandom, 0, 4'hf, lfsrState);
        for (int i = 0; i < lfsrReads / 2; i++) begin
            lfsrRead();
        end
        // zero seed is dropped and the sequence carries on
        writeReg(socMapPkg::regionRandom, 0, 4'hf, 32'd0);
        for (int i = 0; i < lfsrReads / 2; i++) begin
            lfsrRead();
        end
        idleBus();

        // channel 1 alone with its count visible while disabled
        writeReg(socMapPkg::regionTimer, 1, 4'hf, timerReload);
        readExpect(socMapPkg::regionTimer, countBase + 1, timerReload);
        writeReg(socMapPkg::regionTimer, enableAddr, 4'hf, 32'h2);
        idleBus();
        waitForRequest(timerReload + 4, riseAt);
        expectEqual("irqNumber", 1, irqNumber);
        for (int p = 1; p < timerPulses; p++) begin
            acknowledge(1);
            prevRise = riseAt;
            waitForRequest(timerReload + 4, riseAt);
            expectEqual("irqNumber", 1, irqNumber);
            expectEqual("interruptRequest period", timerReload + 1, riseAt - prevRise);
        end
        acknowledge(1);
        writeReg(socMapPkg::regionTimer, enableAddr, 4'hf, 32'h0);
        idleBus();

        // channels 0 and 2 start together and fire in the same cycle
        writeReg(socMapPkg::regionTimer, 0, 4'hf, 32'd5);
        writeReg(socMapPkg::regionTimer, 2, 4'hf, 32'd5);
        writeReg(socMapPkg::regionTimer, enableAddr, 4'hf, 32'h5);
        idleBus();
        waitForRequest(12, riseAt);
        expectEqual("irqNumber", 0, irqNumber);
        acknowledge(0);
        writeReg(socMapPkg::regionTimer, enableAddr, 4'hf, 32'h0);
        idleBus();
        expectEqual("interruptRequest", 1, interruptRequest);
        expectEqual("irqNumber", 2, irqNumber);
        acknowledge(2);
        @(posedge clk);
        expectEqual("interruptRequest", 0, interruptRequest);

        // region 3 has no slave
        readExpect(8'd3, 0, 32'd0);
        idleBus();

        repeat (3) @(posedge clk);
        assert (expectedData.size() == 0) else begin
            reportFailure("reads left without an answer");
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // run length bound
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("%0t: watchdog expired after %0d cycles, errors: %0d", $time,
                 watchdogCycles, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sources.f
hdl/socBusPkg.sv
hdl/socMapPkg.sv
hdl/busInterconnect.sv
hdl/scratchRam.sv
hdl/lfsrRandom.sv
hdl/systemTimer.sv
hdl/interruptController.sv
hdl/decaSoc.sv
verif/decaSocTb.sv
